/* sources.f */
rtl/irq_pkg.sv
rtl/irq_cfg_if.sv
rtl/irq_regs.sv
rtl/irq_prioritizer.sv
rtl/irq_ack_port.sv
rtl/irq_controller.sv
verification/tb_irq_controller.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_irq_controller
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the simulator output.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_irq_controller.sv */
`timescale 1ns/1ns

module tb_irq_controller import irq_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int SETTLE_CYCLES = 4;
    localparam int STEP_CYCLES = 16;
    localparam int RAND_ROUNDS = 8;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_LINES, K_ACK, K_CHECK} step_kind_t;

    typedef struct packed {
        step_kind_t   kind;
        logic         addr;
        bus_bytesel_t sel;
        bus_data_t    data;
        irq_mask_t    lines;
        bus_data_t    exp_data;
        irq_vector_t  exp_vec;
        logic         exp_intr;
        logic         exp_nmi;
    } step_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         cs;
    logic [1:1]   data_m_addr;
    bus_data_t    data_m_data_in;
    bus_data_t    data_m_data_out;
    bus_bytesel_t data_m_bytesel;
    logic         data_m_wr_en;
    logic         data_m_access;
    logic         data_m_ack;
    irq_mask_t    irq_lines;
    logic         inta_req;
    logic         inta_ack;
    irq_vector_t  inta_vector;
    logic         intr;
    logic         nmi;

    step_t steps[$];
    string names[$];
    logic  table_ready = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    irq_controller dut0 (.*);

    // ########################################
    // Reference rules and table building
    // ########################################

    // line 7 is never gated, test bits ignore the mask.
    function automatic irq_mask_t pending_of(irq_mask_t lines, irq_mask_t en, irq_mask_t test);
        return (lines & (en | 8'h80)) | test;
    endfunction

    function automatic irq_vector_t vector_of(irq_mask_t pend, irq_vector_t base);
        for (int i = 0; i < 7; i++) begin
            if (pend[i])
                return base + irq_vector_t'(i);
        end
        return base + 8'd7;
    endfunction

    function automatic void push_step(step_kind_t kind, string name, logic addr,
                                      bus_bytesel_t sel, bus_data_t data, irq_mask_t lines,
                                      bus_data_t exp_data, irq_vector_t exp_vec,
                                      logic exp_intr, logic exp_nmi);
        steps.push_back('{kind, addr, sel, data, lines, exp_data, exp_vec, exp_intr, exp_nmi});
        names.push_back(name);
    endfunction

    function automatic void build_table();
        irq_mask_t rnd;
        irq_mask_t pend;
        push_step(K_READ, "rd_ctrl_rst", 1'b0, 2'b11, '0, '0, 16'h0000, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_enable", 1'b0, 2'b01, 16'h12FF, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_READ, "rd_enable", 1'b0, 2'b11, '0, '0, 16'h00FF, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_base", 1'b0, 2'b10, 16'h40AA, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_READ, "rd_base", 1'b0, 2'b11, '0, '0, 16'h40FF, '0, 1'b0, 1'b0);
        push_step(K_READ, "rd_low_lane", 1'b0, 2'b01, '0, '0, 16'h00FF, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_status", 1'b1, 2'b10, 16'hFF00, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_READ, "rd_status", 1'b1, 2'b11, '0, '0, 16'h0000, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_en_off", 1'b0, 2'b01, 16'h0000, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_test_28", 1'b1, 2'b01, 16'h0028, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_CHECK, "chk_test_28", 1'b0, '0, '0, '0, '0, '0, 1'b1, 1'b0);
        push_step(K_READ, "rd_test_28", 1'b1, 2'b11, '0, '0, 16'h2828, '0, 1'b0, 1'b0);
        push_step(K_ACK, "ack_test_28", 1'b0, '0, '0, '0, '0, 8'h43, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_test_20", 1'b1, 2'b01, 16'h0020, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_ACK, "ack_test_20", 1'b0, '0, '0, '0, '0, 8'h45, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_test_80", 1'b1, 2'b01, 16'h0080, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_CHECK, "chk_test_80", 1'b0, '0, '0, '0, '0, '0, 1'b0, 1'b1);
        push_step(K_ACK, "ack_spur_80", 1'b0, '0, '0, '0, '0, 8'h47, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_test_81", 1'b1, 2'b01, 16'h0081, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_ACK, "ack_test_81", 1'b0, '0, '0, '0, '0, 8'h40, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_test_off", 1'b1, 2'b01, 16'h0000, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_LINES, "lines_0c", 1'b0, '0, '0, 8'h0C, '0, '0, 1'b0, 1'b0);
        push_step(K_READ, "rd_masked", 1'b1, 2'b11, '0, '0, 16'h0000, '0, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_en_08", 1'b0, 2'b01, 16'h0008, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_CHECK, "chk_en_08", 1'b0, '0, '0, '0, '0, '0, 1'b1, 1'b0);
        push_step(K_READ, "rd_en_08", 1'b1, 2'b11, '0, '0, 16'h0800, '0, 1'b0, 1'b0);
        push_step(K_ACK, "ack_line_3", 1'b0, '0, '0, '0, '0, 8'h43, 1'b0, 1'b0);
        push_step(K_LINES, "lines_80", 1'b0, '0, '0, 8'h80, '0, '0, 1'b0, 1'b1);
        push_step(K_ACK, "ack_spur_l7", 1'b0, '0, '0, '0, '0, 8'h47, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_base_fc", 1'b0, 2'b11, 16'hFC7F, '0, '0, '0, 1'b0, 1'b0);
        push_step(K_LINES, "lines_40", 1'b0, '0, '0, 8'h40, '0, '0, 1'b1, 1'b0);
        push_step(K_ACK, "ack_wrap", 1'b0, '0, '0, '0, '0, 8'h02, 1'b0, 1'b0);
        push_step(K_LINES, "lines_00", 1'b0, '0, '0, 8'h00, '0, '0, 1'b0, 1'b0);
        push_step(K_ACK, "ack_spur_wrap", 1'b0, '0, '0, '0, '0, 8'h03, 1'b0, 1'b0);
        push_step(K_WRITE, "wr_rand_cfg", 1'b0, 2'b11, 16'h9035, '0, '0, '0, 1'b0, 1'b0);
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            rnd = irq_mask_t'($urandom);
            pend = pending_of(rnd, 8'h35, 8'h00);
            push_step(K_LINES, $sformatf("rand_lines_%0d", i), 1'b0, '0, '0, rnd, '0, '0,
                      |pend[6:0], pend[7]);
            push_step(K_ACK, $sformatf("rand_ack_%0d", i), 1'b0, '0, '0, '0, '0,
                      vector_of(pend, 8'h90), 1'b0, 1'b0);
        end
    endfunction

    // ########################################
    // Checks and step execution
    // ########################################

    task automatic stop_on_error();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(string name, bus_data_t exp, bus_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_vector(string name, irq_vector_t exp, irq_vector_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic bus_access(step_t s, string name);
        int waited;
        @(posedge clk);
        cs <= 1'b1;
        data_m_access <= 1'b1;
        data_m_wr_en <= (s.kind == K_WRITE);
        data_m_addr <= s.addr;
        data_m_bytesel <= s.sel;
        data_m_data_in <= s.data;
        @(negedge clk);
        waited = 1;
        while (!data_m_ack) begin
            @(negedge clk);
            waited++;
        end
        // the slave sees the request one cycle after it is driven and acks in the next.
        if (waited != 2) begin
            $display("bus ack for %s came %0d half-open cycles after the request", name, waited);
            stop_on_error();
        end
        check_data(name, s.exp_data, data_m_data_out);
        @(posedge clk);
        cs <= 1'b0;
        data_m_access <= 1'b0;
        data_m_wr_en <= 1'b0;
        if (s.kind == K_WRITE)
            settle();
    endtask

    task automatic acknowledge(step_t s, string name);
        @(posedge clk);
        inta_req <= 1'b1;
        @(negedge clk);
        while (!inta_ack)
            @(negedge clk);
        check_vector(name, s.exp_vec, inta_vector);
        check_flag({name, "_intr_held"}, 1'b0, intr);
        @(posedge clk);
        inta_req <= 1'b0;
        @(negedge clk);
        check_flag({name, "_ack_hold"}, 1'b1, inta_ack);
        while (inta_ack)
            @(negedge clk);
        settle();
    endtask

    task automatic run_step(int idx);
        step_t s;
        s = steps[idx];
        case (s.kind)
            K_WRITE, K_READ: bus_access(s, names[idx]);
            K_ACK: acknowledge(s, names[idx]);
            default: begin
                if (s.kind == K_LINES) begin
                    @(posedge clk);
                    irq_lines <= s.lines;
                    settle();
                end
                check_flag({names[idx], "_intr"}, s.exp_intr, intr);
                check_flag({names[idx], "_nmi"}, s.exp_nmi, nmi);
            end
        endcase
    endtask

    initial begin
        wait (table_ready);
        #((steps.size() * STEP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all steps completed");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset <= 1'b1;
        cs <= 1'b0;
        data_m_addr <= 1'b0;
        data_m_data_in <= '0;
        data_m_bytesel <= '0;
        data_m_wr_en <= 1'b0;
        data_m_access <= 1'b0;
        irq_lines <= '0;
        inta_req <= 1'b0;
        void'($urandom(32'h5388));
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < steps.size(); i++)
            run_step(i);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* rtl/irq_controller.sv */
`timescale 1ns/1ns

module irq_controller import irq_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         cs,
    input  logic [1:1]   data_m_addr,
    input  bus_data_t    data_m_data_in,
    output bus_data_t    data_m_data_out,
    input  bus_bytesel_t data_m_bytesel,
    input  logic         data_m_wr_en,
    input  logic         data_m_access,
    output logic         data_m_ack,
    input  irq_mask_t    irq_lines,
    input  logic         inta_req,
    output logic         inta_ack,
    output irq_vector_t  inta_vector,
    output logic         intr,
    output logic         nmi
);

    logic        intr_pending;
    logic        winner_valid;
    irq_vector_t winner_vector;

    irq_cfg_if cfg0 ();

    irq_regs regs0 (
        .clk             (clk),
        .reset           (reset),
        .cs              (cs),
        .data_m_addr     (data_m_addr),
        .data_m_data_in  (data_m_data_in),
        .data_m_data_out (data_m_data_out),
        .data_m_bytesel  (data_m_bytesel),
        .data_m_wr_en    (data_m_wr_en),
        .data_m_access   (data_m_access),
        .data_m_ack      (data_m_ack),
        .cfg             (cfg0.regs)
    );

    irq_prioritizer prio0 (
        .clk           (clk),
        .reset         (reset),
        .irq_lines     (irq_lines),
        .cfg           (cfg0.prio),
        .intr_pending  (intr_pending),
        .winner_valid  (winner_valid),
        .winner_vector (winner_vector),
        .nmi           (nmi)
    );

    irq_ack_port ack0 (
        .clk           (clk),
        .reset         (reset),
        .intr_pending  (intr_pending),
        .winner_valid  (winner_valid),
        .winner_vector (winner_vector),
        .vector_base   (cfg0.vector_base),
        .inta_req      (inta_req),
        .inta_ack      (inta_ack),
        .inta_vector   (inta_vector),
        .intr          (intr)
    );

endmodule

/* rtl/irq_ack_port.sv */
`timescale 1ns/1ns

module irq_ack_port import irq_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        intr_pending,
    input  logic        winner_valid,
    input  irq_vector_t winner_vector,
    input  irq_vector_t vector_base,
    input  logic        inta_req,
    output logic        inta_ack,
    output irq_vector_t inta_vector,
    output logic        intr
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACKED,
        ST_RELEASE
    } ack_state_t;

    ack_state_t  state;
    irq_vector_t spurious_vector;

    assign spurious_vector = vector_base + irq_vector_t'(SPURIOUS_INDEX);

    // ########################################
    // Four-phase handshake
    // ########################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            inta_ack <= 1'b0;
            inta_vector <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (inta_req) begin
                        inta_ack <= 1'b1;
                        inta_vector <= winner_valid ? winner_vector : spurious_vector;
                        state <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // vector stays frozen until the processor lets go.
                    if (!inta_req) begin
                        inta_ack <= 1'b0;
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    inta_ack <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // intr is held off for the whole acknowledge cycle, release included.
    assign intr = intr_pending && (state == ST_IDLE);

endmodule

/* rtl/irq_prioritizer.sv */
`timescale 1ns/1ns

module irq_prioritizer import irq_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  irq_mask_t   irq_lines,
    irq_cfg_if.prio     cfg,
    output logic        intr_pending,
    output logic        winner_valid,
    output irq_vector_t winner_vector,
    output logic        nmi
);

    irq_mask_t   lines_meta;
    irq_mask_t   lines_sync;
    irq_mask_t   line_gate;
    irq_mask_t   pending;
    irq_vector_t win_idx;
    logic        any_maskable;

    // two-flop synchronizer for the external level inputs.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lines_meta <= '0;
            lines_sync <= '0;
        end else begin
            lines_meta <= irq_lines;
            lines_sync <= lines_meta;
        end
    end

    // the NMI line passes regardless of its enable bit.
    always_comb begin
        line_gate = cfg.enable_mask;
        line_gate[NMI_LINE] = 1'b1;
    end

    assign pending = (lines_sync & line_gate) | cfg.test_pending;
    assign cfg.pending = pending;

    assign any_maskable = |pending[MASKABLE_LINES-1:0];

    // scan downwards so the lowest set index is left in win_idx.
    always_comb begin
        win_idx = '0;
        for (int i = MASKABLE_LINES - 1; i >= 0; i--) begin
            if (pending[i])
                win_idx = irq_vector_t'(i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            intr_pending <= 1'b0;
            winner_valid <= 1'b0;
            winner_vector <= '0;
            nmi <= 1'b0;
        end else begin
            intr_pending <= any_maskable;
            winner_valid <= any_maskable;
            winner_vector <= cfg.vector_base + win_idx;
            nmi <= pending[NMI_LINE];
        end
    end

endmodule

/* rtl/irq_regs.sv */
`timescale 1ns/1ns

module irq_regs import irq_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         cs,
    input  logic [1:1]   data_m_addr,
    input  bus_data_t    data_m_data_in,
    output bus_data_t    data_m_data_out,
    input  bus_bytesel_t data_m_bytesel,
    input  logic         data_m_wr_en,
    input  logic         data_m_access,
    output logic         data_m_ack,
    irq_cfg_if.regs      cfg
);

    logic        bus_sel;
    logic        wr_first;
    logic        sel_ctrl;
    logic        sel_status;
    logic [7:0]  rd_low;
    logic [7:0]  rd_high;
    irq_mask_t   enable_reg;
    irq_mask_t   test_reg;
    irq_vector_t base_reg;

    assign bus_sel = cs & data_m_access;

    // the ack of the previous cycle marks the second cycle of the same access.
    assign wr_first = bus_sel & data_m_wr_en & ~data_m_ack;

    assign sel_ctrl = data_m_addr[1] == BUS_WORD_CTRL;
    assign sel_status = data_m_addr[1] == BUS_WORD_STATUS;

    // ########################################
    // Writable registers
    // ########################################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_reg <= '0;
            base_reg <= '0;
            test_reg <= '0;
        end else if (wr_first) begin
            if (sel_ctrl && data_m_bytesel[LANE_LOW])
                enable_reg <= data_m_data_in[7:0];
            if (sel_ctrl && data_m_bytesel[LANE_HIGH])
                base_reg <= data_m_data_in[15:8];
            // writing test bit 7 raises nmi directly.
            if (sel_status && data_m_bytesel[LANE_LOW])
                test_reg <= data_m_data_in[7:0];
        end
    end

    assign cfg.enable_mask = enable_reg;
    assign cfg.test_pending = test_reg;
    assign cfg.vector_base = base_reg;

    // ########################################
    // Read path and ack
    // ########################################

    always_comb begin
        rd_low = '0;
        rd_high = '0;
        if (data_m_bytesel[LANE_LOW])
            rd_low = sel_ctrl ? enable_reg : test_reg;
        if (data_m_bytesel[LANE_HIGH])
            rd_high = sel_ctrl ? base_reg : cfg.pending;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_m_ack <= 1'b0;
            data_m_data_out <= '0;
        end else begin
            data_m_ack <= bus_sel;
            data_m_data_out <= (bus_sel && !data_m_wr_en) ? {rd_high, rd_low} : '0;
        end
    end

endmodule

/* rtl/irq_cfg_if.sv */
`timescale 1ns/1ns

// configuration and status travelling between the register block and the prioritizer.
interface irq_cfg_if import irq_pkg::*; ();

    irq_mask_t   enable_mask;
    irq_mask_t   test_pending;
    irq_vector_t vector_base;

    // pending set as seen by the prioritizer, read back through word 1.
    irq_mask_t   pending;

    modport regs (
        output enable_mask,
        output test_pending,
        output vector_base,
        input  pending
    );

    modport prio (
        input  enable_mask,
        input  test_pending,
        input  vector_base,
        output pending
    );

endinterface

/* rtl/irq_pkg.sv */
package irq_pkg;

    // ########################################
    // Interrupt source layout
    // ########################################

    localparam int NUM_IRQ_LINES = 8;

    // line 7 is the non-maskable source and never produces a vector.
    localparam int NMI_LINE = 7;

    // lines below the NMI line take part in vector selection.
    localparam int MASKABLE_LINES = NMI_LINE;

    // offset added to the vector base when an acknowledge finds nothing pending.
    localparam int SPURIOUS_INDEX = 7;

    // ########################################
    // Register bus layout
    // ########################################

    // word 0 holds enable and base, word 1 holds test and pending status.
    localparam logic BUS_WORD_CTRL = 1'b0;
    localparam logic BUS_WORD_STATUS = 1'b1;

    localparam int LANE_LOW = 0;
    localparam int LANE_HIGH = 1;

    // ########################################
    // Shared types
    // ########################################

    typedef logic [NUM_IRQ_LINES-1:0] irq_mask_t;
    typedef logic [7:0] irq_vector_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0] bus_bytesel_t;

endpackage
